//--- sim.f
hdl/sdram_pkg.sv
hdl/mem_master_if.sv
hdl/sdram_cmd_if.sv
hdl/sdram_arbiter.sv
hdl/sdram_ctrl.sv
hdl/sdram_subsys.sv
verif/tb_sdram_subsys.sv

//--- verif/tb_sdram_subsys.sv
`default_nettype none

module tb_sdram_subsys
    import sdram_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int READ_LATENCY = 5;    // Grant cycle, T_RCD and T_CAS
    localparam int N_RANDOM     = 200;
    localparam int N_DIRECTED   = 87;   // Preload, write/read, burst and priority commands
    localparam int CMD_CYCLES   = 26;   // Burst from grant to idle, plus request turnaround
    localparam int MAX_GAP      = 15;

    // One expected read word
    typedef struct packed {
        addr_t addr;
        data_t data;
        tag_t  tag;
        logic  last;
    } resp_t;

    typedef struct packed {
        logic       to_m2;
        logic       write;
        logic       burst;
        addr_t      address;
        data_t      wdata;
        strb_t      wstrb;
        logic [3:0] gap;
    } rnd_cmd_t;

    logic  clk;
    logic  reset;
    logic  m1_request;
    logic  m1_ready;
    logic  m1_write;
    logic  m1_burst;
    addr_t m1_address;
    data_t m1_wdata;
    strb_t m1_wstrb;
    logic  m1_rvalid;
    addr_t m1_raddress;
    data_t m1_rdata;
    tag_t  m1_rtag;
    logic  m1_complete;
    logic  m2_request;
    logic  m2_ready;
    logic  m2_write;
    logic  m2_burst;
    addr_t m2_address;
    data_t m2_wdata;
    strb_t m2_wstrb;
    logic  m2_rvalid;
    addr_t m2_raddress;
    data_t m2_rdata;
    tag_t  m2_rtag;
    logic  m2_complete;

    data_t       shadow [0:(1 << MEM_INDEX_BITS) - 1];  // Model of the word array
    resp_t       exp_q1 [$];
    resp_t       exp_q2 [$];
    resp_t       head1;
    resp_t       head2;
    logic        head1_valid = 1'b0;
    logic        head2_valid = 1'b0;
    logic        pop1 = 1'b0;                           // Head was consumed last cycle
    logic        pop2 = 1'b0;
    resp_t       resp1;
    resp_t       resp2;
    rnd_cmd_t    rnd_cmds [N_RANDOM];
    string       test_name;
    int          seed = 76;
    int unsigned cycle_cnt = 0;

    sdram_subsys i_dut (.*);

    assign resp1 = {m1_raddress, m1_rdata, m1_rtag, m1_complete};
    assign resp2 = {m2_raddress, m2_rdata, m2_rtag, m2_complete};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic string format_resp(input resp_t r);
        return $sformatf("addr=%h data=%h tag=%h complete=%b", r.addr, r.data, r.tag, r.last);
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s: %s", test_name, msg);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    task automatic mismatch(input string what, input resp_t expected, input resp_t actual);
        $display("ERR %s %s: expected %s, actual %s", test_name, what,
                 format_resp(expected), format_resp(actual));
        $display("=== FAIL ===");
        $fatal(1, "response mismatch");
    endtask

    // Writes update the model at once, reads queue the words they will return
    task automatic record_grant(input int m, input logic wr, input logic bu, input addr_t a,
                                input data_t d, input strb_t s);
        resp_t e;
        addr_t wa;
        int    n;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    shadow[a[MEM_INDEX_BITS+1:2]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end else begin
            n = bu ? BURST_WORDS : 1;
            for (int k = 0; k < n; k++) begin
                wa     = bu ? {a[25:6], k[3:0], 2'b00} : a;  // Burst walks the aligned block
                e.addr = wa;
                e.data = shadow[wa[MEM_INDEX_BITS+1:2]];
                e.tag  = d[8:0];
                e.last = (k == n - 1);
                if (m == 1) begin
                    exp_q1.push_back(e);
                end else begin
                    exp_q2.push_back(e);
                end
            end
        end
    endtask

    // Hold one request until its grant pulse, then drop it
    task automatic issue_cmd(input int m, input logic wr, input logic bu, input addr_t a,
                             input data_t d, input strb_t s);
        @(posedge clk);
        #1;
        if (m == 1) begin
            m1_write   = wr;
            m1_burst   = bu;
            m1_address = a;
            m1_wdata   = d;
            m1_wstrb   = s;
            m1_request = 1'b1;
        end else begin
            m2_write   = wr;
            m2_burst   = bu;
            m2_address = a;
            m2_wdata   = d;
            m2_wstrb   = s;
            m2_request = 1'b1;
        end
        do begin
            @(negedge clk);
        end while (!(m == 1 ? m1_ready : m2_ready));
        @(posedge clk);
        #1;
        if (m == 1) begin
            m1_request = 1'b0;
        end else begin
            m2_request = 1'b0;
        end
    endtask

    task automatic run_stream(input logic second);
        for (int i = 0; i < N_RANDOM; i++) begin
            if (rnd_cmds[i].to_m2 == second) begin
                repeat (rnd_cmds[i].gap) @(posedge clk);
                issue_cmd(second ? 2 : 1, rnd_cmds[i].write, rnd_cmds[i].burst,
                          rnd_cmds[i].address, rnd_cmds[i].wdata, rnd_cmds[i].wstrb);
            end
        end
    endtask

    task automatic wait_drained();
        for (int i = 0; i < 4 * CMD_CYCLES; i++) begin
            if (exp_q1.size() == 0 && exp_q2.size() == 0) begin
                break;
            end
            @(posedge clk);
        end
    endtask

    // Expected responses follow the grant order
    always @(negedge clk) begin
        if (pop1 && exp_q1.size() > 0) begin
            void'(exp_q1.pop_front());
        end
        if (pop2 && exp_q2.size() > 0) begin
            void'(exp_q2.pop_front());
        end
        if (m1_ready === 1'b1) begin
            record_grant(1, m1_write, m1_burst, m1_address, m1_wdata, m1_wstrb);
        end
        if (m2_ready === 1'b1) begin
            record_grant(2, m2_write, m2_burst, m2_address, m2_wdata, m2_wstrb);
        end
        head1_valid = (exp_q1.size() > 0);
        head2_valid = (exp_q2.size() > 0);
        if (head1_valid) begin
            head1 = exp_q1[0];
        end
        if (head2_valid) begin
            head2 = exp_q2[0];
        end
        pop1 = (m1_rvalid === 1'b1);
        pop2 = (m2_rvalid === 1'b1);
    end

    // Quiet outputs through reset and the first cycles after it
    a_reset_quiet: assert property (@(posedge clk)
        (cycle_cnt inside {[1:6]}) |-> !(m1_ready || m2_ready || m1_rvalid || m2_rvalid))
        else stop_with_error("a ready or rvalid output was high around reset");

    a_priority: assert property (@(posedge clk) disable iff (reset)
        m2_ready |-> !m1_request)
        else stop_with_error("master 2 was granted while master 1 was requesting");

    a_m1_latency: assert property (@(posedge clk) disable iff (reset)
        (m1_ready && !m1_write) |-> (!m1_rvalid) [*READ_LATENCY] ##1 m1_rvalid)
        else stop_with_error("master 1 read data did not start 5 cycles after the grant");

    a_m2_latency: assert property (@(posedge clk) disable iff (reset)
        (m2_ready && !m2_write) |-> (!m2_rvalid) [*READ_LATENCY] ##1 m2_rvalid)
        else stop_with_error("master 2 read data did not start 5 cycles after the grant");

    a_m1_expected: assert property (@(posedge clk) disable iff (reset)
        m1_rvalid |-> head1_valid)
        else stop_with_error("master 1 got read data with no read outstanding");

    a_m2_expected: assert property (@(posedge clk) disable iff (reset)
        m2_rvalid |-> head2_valid)
        else stop_with_error("master 2 got read data with no read outstanding");

    a_m1_resp: assert property (@(posedge clk) disable iff (reset)
        (m1_rvalid && head1_valid) |-> (resp1 === head1))
        else mismatch("m1 response", $sampled(head1), $sampled(resp1));

    a_m2_resp: assert property (@(posedge clk) disable iff (reset)
        (m2_rvalid && head2_valid) |-> (resp2 === head2))
        else mismatch("m2 response", $sampled(head2), $sampled(resp2));

    initial begin
        logic [31:0] r;
        m1_request = 1'b0;
        m1_write   = 1'b0;
        m1_burst   = 1'b0;
        m1_address = '0;
        m1_wdata   = '0;
        m1_wstrb   = '0;
        m2_request = 1'b0;
        m2_write   = 1'b0;
        m2_burst   = 1'b0;
        m2_address = '0;
        m2_wdata   = '0;
        m2_wstrb   = '0;
        reset      = 1'b1;
        test_name  = "reset";
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);

        // Known contents for the 64-word window
        test_name = "preload";
        for (int i = 0; i < 64; i++) begin
            issue_cmd(2, 1'b1, 1'b0, addr_t'(i * 4), {6'h2b, addr_t'(i * 4)}, 4'hF);
        end

        test_name = "write_read";
        issue_cmd(1, 1'b1, 1'b0, 26'h000_0014, 32'h1122_3344, 4'hF);
        issue_cmd(1, 1'b1, 1'b0, 26'h010_0014, 32'haabb_ccdd, 4'b0101);  // Alias of same word
        issue_cmd(1, 1'b0, 1'b0, 26'h000_0016, 32'h0000_01a5, 4'h0);
        wait_drained();

        test_name = "burst_read";
        for (int k = 0; k < BURST_WORDS; k++) begin
            issue_cmd(2, 1'b1, 1'b0, addr_t'(32'h80 + k * 4),
                      32'hb000_0000 + k * 32'h0001_0101, 4'hF);
        end
        issue_cmd(1, 1'b0, 1'b1, 26'h000_c09c, 32'h0000_00f3, 4'h0);  // Aliases block 0x80
        wait_drained();

        test_name = "priority";
        fork
            begin
                issue_cmd(1, 1'b0, 1'b0, 26'h000_0040, 32'h0000_0111, 4'h0);
                issue_cmd(1, 1'b0, 1'b1, 26'h000_0000, 32'h0000_0122, 4'h0);
            end
            issue_cmd(2, 1'b0, 1'b0, 26'h000_00fc, 32'h0000_0133, 4'h0);
        join
        wait_drained();

        test_name = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            rnd_cmds[i].to_m2   = r[2];
            rnd_cmds[i].write   = (r[1:0] < 2'd2);
            rnd_cmds[i].burst   = (r[1:0] == 2'd3);
            rnd_cmds[i].gap     = r[11:8];
            rnd_cmds[i].wstrb   = r[15:12];
            r = $random(seed);
            rnd_cmds[i].address = {r[27:16], 6'b0, r[7:0]};  // Window aliased above bit 13
            rnd_cmds[i].wdata   = $random(seed);
        end
        fork
            run_stream(1'b0);
            run_stream(1'b1);
        join
        wait_drained();

        if (exp_q1.size() == 0 && exp_q2.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%s: read responses were still outstanding at the end", test_name);
            $display("=== FAIL ===");
            $fatal(1, "responses outstanding");
        end
    end

    initial begin
        #(CLK_PERIOD * (N_DIRECTED + N_RANDOM) * (CMD_CYCLES + MAX_GAP) * 2);
        $display("Watchdog expired, the DUT stopped granting or returning read data");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- hdl/sdram_subsys.sv
`default_nettype none

module sdram_subsys
    import sdram_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Master 1
    input  wire logic  m1_request,
    output logic       m1_ready,
    input  wire logic  m1_write,
    input  wire logic  m1_burst,
    input  wire addr_t m1_address,
    input  wire data_t m1_wdata,     // Write data or read tag
    input  wire strb_t m1_wstrb,
    output logic       m1_rvalid,
    output addr_t      m1_raddress,
    output data_t      m1_rdata,
    output tag_t       m1_rtag,
    output logic       m1_complete,

    // Master 2
    input  wire logic  m2_request,
    output logic       m2_ready,
    input  wire logic  m2_write,
    input  wire logic  m2_burst,
    input  wire addr_t m2_address,
    input  wire data_t m2_wdata,
    input  wire strb_t m2_wstrb,
    output logic       m2_rvalid,
    output addr_t      m2_raddress,
    output data_t      m2_rdata,
    output tag_t       m2_rtag,
    output logic       m2_complete
);

    mem_master_if m1_if ();
    mem_master_if m2_if ();
    sdram_cmd_if  cmd_if ();

    assign m1_if.request = m1_request;
    assign m1_if.write   = m1_write;
    assign m1_if.burst   = m1_burst;
    assign m1_if.address = m1_address;
    assign m1_if.wdata   = m1_wdata;
    assign m1_if.wstrb   = m1_wstrb;
    assign m1_ready      = m1_if.ready;
    assign m1_rvalid     = m1_if.rvalid;
    assign m1_raddress   = m1_if.raddress;
    assign m1_rdata      = m1_if.rdata;
    assign m1_rtag       = m1_if.rtag;
    assign m1_complete   = m1_if.complete;

    assign m2_if.request = m2_request;
    assign m2_if.write   = m2_write;
    assign m2_if.burst   = m2_burst;
    assign m2_if.address = m2_address;
    assign m2_if.wdata   = m2_wdata;
    assign m2_if.wstrb   = m2_wstrb;
    assign m2_ready      = m2_if.ready;
    assign m2_rvalid     = m2_if.rvalid;
    assign m2_raddress   = m2_if.raddress;
    assign m2_rdata      = m2_if.rdata;
    assign m2_rtag       = m2_if.rtag;
    assign m2_complete   = m2_if.complete;

    sdram_arbiter i_arbiter (
        .clk   (clk),
        .reset (reset),
        .m1    (m1_if.arbiter),
        .m2    (m2_if.arbiter),
        .cmd   (cmd_if.arbiter)
    );

    sdram_ctrl i_ctrl (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_if.controller)
    );

endmodule

`default_nettype wire

//--- hdl/sdram_ctrl.sv
`default_nettype none

module sdram_ctrl
    import sdram_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    sdram_cmd_if.controller cmd
);

    localparam int BEAT_BITS = $clog2(BURST_WORDS);

    ctrl_state_t state;
    logic [1:0]  wait_cnt;                  // Timing counter within a state
    logic [BEAT_BITS-1:0] beat;             // Word offset within a burst

    // Latched command
    master_sel_t cur_sel;
    addr_t       cur_addr;
    logic        cur_write;
    logic        cur_burst;
    strb_t       cur_wstrb;
    data_t       cur_wdata;
    tag_t        cur_tag;

    logic        new_cmd;
    logic        last_word;
    addr_t       rd_addr;
    logic [MEM_INDEX_BITS-1:0] rd_index;
    logic [MEM_INDEX_BITS-1:0] wr_index;

    // Stand-in for the SDRAM device
    data_t mem [0:(1 << MEM_INDEX_BITS) - 1];

    assign new_cmd   = (state == ST_IDLE) && (cmd.request != MSEL_NONE);
    assign last_word = !cur_burst || (beat == BURST_WORDS - 1);

    // Burst words walk the 64-byte aligned block
    assign rd_addr  = cur_burst ? {cur_addr[$bits(addr_t)-1:6], beat, 2'b00} : cur_addr;
    assign rd_index = rd_addr[MEM_INDEX_BITS+1:2];    // Upper bits alias
    assign wr_index = cur_addr[MEM_INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
            beat     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    wait_cnt <= '0;
                    if (new_cmd) begin
                        state <= ST_ACTIVATE;
                    end
                end
                ST_ACTIVATE: begin
                    if (wait_cnt == T_RCD - 1) begin
                        wait_cnt <= '0;
                        state    <= cur_write ? ST_WRITE : ST_READ_WAIT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_READ_WAIT: begin
                    // Column read goes out on the last activate edge
                    if (wait_cnt == T_CAS - 2) begin
                        wait_cnt <= '0;
                        beat     <= '0;
                        state    <= ST_READ_DATA;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_READ_DATA: begin
                    if (last_word) begin
                        state <= ST_PRECHARGE;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                ST_WRITE: begin
                    state <= ST_PRECHARGE;  // Single-cycle merge
                end
                ST_PRECHARGE: begin
                    if (wait_cnt == T_RP - 1) begin
                        wait_cnt <= '0;
                        state    <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command capture
    always_ff @(posedge clk) begin
        if (new_cmd) begin
            cur_sel   <= cmd.request;
            cur_addr  <= cmd.address;
            cur_write <= cmd.write;
            cur_burst <= cmd.burst;
            cur_wstrb <= cmd.wstrb;
            cur_wdata <= cmd.wdata;
            cur_tag   <= cmd.wdata[$bits(tag_t)-1:0];  // Tag rides in wdata
        end
    end

    // Byte-merged write
    always_ff @(posedge clk) begin
        if (state == ST_WRITE) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (cur_wstrb[b]) begin
                    mem[wr_index][8*b +: 8] <= cur_wdata[8*b +: 8];
                end
            end
        end
    end

    assign cmd.ready    = (state == ST_IDLE) && (cmd.request == MSEL_NONE);
    assign cmd.rvalid   = (state == ST_READ_DATA) ? cur_sel : MSEL_NONE;
    assign cmd.raddress = rd_addr;
    assign cmd.rdata    = mem[rd_index];
    assign cmd.rtag     = cur_tag;
    assign cmd.complete = (state == ST_READ_DATA) && last_word;

    // Burst writes are not supported
    a_no_burst_write: assert property (
        @(posedge clk) disable iff (reset)
        (cmd.request != MSEL_NONE) |-> !(cmd.write && cmd.burst)
    );

    a_rvalid_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(cmd.rvalid)
    );

endmodule

`default_nettype wire

//--- hdl/sdram_arbiter.sv
`default_nettype none

module sdram_arbiter
    import sdram_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    mem_master_if.arbiter m1,
    mem_master_if.arbiter m2,
    sdram_cmd_if.arbiter  cmd
);

    master_sel_t next_request;
    addr_t       next_address;
    logic        next_write;
    logic        next_burst;
    strb_t       next_wstrb;
    data_t       next_wdata;

    logic        m1_sel;
    logic        m2_sel;

    // Grant and next command
    always_comb begin
        next_request = MSEL_NONE;       // Command lasts one cycle
        next_address = cmd.address;     // Payload simply holds
        next_write   = cmd.write;
        next_burst   = cmd.burst;
        next_wstrb   = cmd.wstrb;
        next_wdata   = cmd.wdata;
        m1.ready     = 1'b0;
        m2.ready     = 1'b0;

        if (cmd.ready) begin
            if (m1.request) begin       // Master 1 has priority
                next_request = MSEL_M1;
                next_address = m1.address;
                next_write   = m1.write;
                next_burst   = m1.burst;
                next_wstrb   = m1.wstrb;
                next_wdata   = m1.wdata;
                m1.ready     = 1'b1;
            end else if (m2.request) begin
                next_request = MSEL_M2;
                next_address = m2.address;
                next_write   = m2.write;
                next_burst   = m2.burst;
                next_wstrb   = m2.wstrb;
                next_wdata   = m2.wdata;
                m2.ready     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.request <= MSEL_NONE;
        end else begin
            cmd.request <= next_request;
        end
    end

    always_ff @(posedge clk) begin
        cmd.address <= next_address;
        cmd.write   <= next_write;
        cmd.burst   <= next_burst;
        cmd.wstrb   <= next_wstrb;
        cmd.wdata   <= next_wdata;
    end

    // Read return routing by the one-hot select
    assign m1_sel = (cmd.rvalid == MSEL_M1);
    assign m2_sel = (cmd.rvalid == MSEL_M2);

    always_comb begin
        m1.rvalid   = m1_sel;
        m1.raddress = m1_sel ? cmd.raddress : '0;
        m1.rdata    = m1_sel ? cmd.rdata    : '0;
        m1.rtag     = m1_sel ? cmd.rtag     : '0;
        m1.complete = m1_sel & cmd.complete;

        m2.rvalid   = m2_sel;
        m2.raddress = m2_sel ? cmd.raddress : '0;
        m2.rdata    = m2_sel ? cmd.rdata    : '0;
        m2.rtag     = m2_sel ? cmd.rtag     : '0;
        m2.complete = m2_sel & cmd.complete;
    end

    // Never grant both masters in one cycle
    a_single_grant: assert property (
        @(posedge clk) disable iff (reset)
        !(m1.ready && m2.ready)
    );

    // A command only follows a cycle in which the controller was free
    a_cmd_after_ready: assert property (
        @(posedge clk) disable iff (reset)
        (cmd.request != MSEL_NONE) |-> $past(cmd.ready)
    );

endmodule

`default_nettype wire

//--- hdl/sdram_cmd_if.sv
`default_nettype none

interface sdram_cmd_if
    import sdram_pkg::*;
();

    // Command toward the controller
    master_sel_t request;   // Nonzero for one cycle per command
    addr_t       address;
    logic        write;
    logic        burst;
    strb_t       wstrb;
    data_t       wdata;

    // Return path
    logic        ready;     // Controller idle and free
    master_sel_t rvalid;    // Which master gets the read word
    addr_t       raddress;
    data_t       rdata;
    tag_t        rtag;
    logic        complete;

    modport arbiter (
        output request, address, write, burst, wstrb, wdata,
        input  ready, rvalid, raddress, rdata, rtag, complete
    );

    modport controller (
        input  request, address, write, burst, wstrb, wdata,
        output ready, rvalid, raddress, rdata, rtag, complete
    );

endinterface

`default_nettype wire

//--- hdl/mem_master_if.sv
`default_nettype none

interface mem_master_if
    import sdram_pkg::*;
();

    // Request side
    logic   request;   // Held until ready
    logic   write;     // 1 = write, 0 = read
    logic   burst;     // 1 = 16-word read burst
    addr_t  address;
    data_t  wdata;     // Write data, or tag in the low bits for a read
    strb_t  wstrb;

    // Response side
    logic   ready;     // One-cycle grant pulse
    logic   rvalid;
    addr_t  raddress;
    data_t  rdata;
    tag_t   rtag;
    logic   complete;  // Last word of the read

    modport master (
        output request, write, burst, address, wdata, wstrb,
        input  ready, rvalid, raddress, rdata, rtag, complete
    );

    modport arbiter (
        input  request, write, burst, address, wdata, wstrb,
        output ready, rvalid, raddress, rdata, rtag, complete
    );

endinterface

`default_nettype wire

//--- hdl/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // Bus field widths
    typedef logic [25:0] addr_t;        // Byte address
    typedef logic [31:0] data_t;        // Data word, also carries the read tag
    typedef logic [3:0]  strb_t;        // One strobe per byte lane
    typedef logic [8:0]  tag_t;         // Read tag echoed by the controller
    typedef logic [2:0]  master_sel_t;  // One-hot master select

    // Master select codes, bit 2 is kept for a third master
    localparam master_sel_t MSEL_NONE = 3'b000;
    localparam master_sel_t MSEL_M1   = 3'b001;
    localparam master_sel_t MSEL_M2   = 3'b010;

    localparam int BURST_WORDS    = 16;  // 64-byte burst
    localparam int MEM_INDEX_BITS = 12;  // Stand-in array is 4096 words

    // Controller timing in clock cycles
    localparam int T_RCD = 2;  // Activate to access
    localparam int T_CAS = 2;  // Read access to first data
    localparam int T_RP  = 1;  // Precharge

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACTIVATE,
        ST_READ_WAIT,
        ST_READ_DATA,
        ST_WRITE,
        ST_PRECHARGE
    } ctrl_state_t;

endpackage

`default_nettype wire
